// File: common/ising_readout_params.svh
////////////////////////////////////////////////////////////
// Ising readout build parameters
// Spin count, synchronizer depth limit and counter widths
////////////////////////////////////////////////////////////

`ifndef ISING_READOUT_PARAMS_SVH
`define ISING_READOUT_PARAMS_SVH

// Number of spins driven by the analog macro
`define ISING_NUM_SPIN 16

// Longest synchronizer chain that is built
// Configured depth may be anything from 1 up to this value
`define ISING_SYNC_MAX_DEPTH 4

// Run time counter width, saturates at all ones
`define ISING_TIMER_WIDTH 16

// Result sequence number width
`define ISING_INDEX_WIDTH 8

`endif

// File: common/ising_readout_pkg.sv
////////////////////////////////////////////////////////////
// Ising readout shared types
// Spin vector, synchronizer configuration, run time, index
////////////////////////////////////////////////////////////

`default_nettype none

`include "ising_readout_params.svh"

package ising_readout_pkg;

    // One bit per analog spin node
    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    // Configured synchronizer depth, legal range 1 to max depth
    typedef logic [2:0] sync_depth_t;

    // One-shot captures once per finish edge, continuous keeps shifting
    typedef enum logic {
        SYNC_ONE_SHOT   = 1'b0,
        SYNC_CONTINUOUS = 1'b1
    } sync_mode_e;

    // Anneal run time in clock cycles
    typedef logic [`ISING_TIMER_WIDTH-1:0] run_cycles_t;

    // Result sequence number
    typedef logic [`ISING_INDEX_WIDTH-1:0] run_index_t;

endpackage

`default_nettype wire

// File: analog_tx/step_counter.sv
////////////////////////////////////////////////////////////
// Step counter
// Loadable down-counter that pulses overflow when it expires
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module step_counter #(
    parameter int COUNTER_WIDTH = 3
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     en_i,
    input  logic                     load_i,
    input  logic [COUNTER_WIDTH-1:0] d_i,
    input  logic                     recount_en_i,
    input  logic                     step_en_i,
    output logic                     overflow_o
);

    logic [COUNTER_WIDTH-1:0] reload_q;
    logic [COUNTER_WIDTH-1:0] count_q;
    logic [COUNTER_WIDTH-1:0] start_value;
    logic                     active_q;
    logic                     last_step;

    // Load and recount together start from the new value
    assign start_value = load_i ? d_i : reload_q;
    // A reload of zero behaves like one
    assign last_step   = (count_q <= COUNTER_WIDTH'(1));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reload_q <= '0;
        end else if (en_i && load_i) begin
            reload_q <= d_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q    <= '0;
            active_q   <= 1'b0;
            overflow_o <= 1'b0;
        end else if (!en_i) begin
            active_q   <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= 1'b0;
            if (recount_en_i) begin
                count_q  <= start_value;
                active_q <= 1'b1;
            end else if (active_q && step_en_i) begin
                if (last_step) begin
                    // Expired, wait for the next recount
                    active_q   <= 1'b0;
                    overflow_o <= 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: analog_tx/analog_tx.sv
////////////////////////////////////////////////////////////
// Analog spin transmitter
// Brings the analog spin vector into the clock domain through
// a configurable synchronizer chain, offered on valid/ready
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "ising_readout_params.svh"

module analog_tx
    import ising_readout_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic        cfg_we_i,
    input  sync_depth_t cfg_sync_depth_i,
    input  sync_mode_e  cfg_sync_mode_i,
    input  spin_vec_t   spin_i,
    input  logic        cmpt_finish_i,
    input  logic        spin_ready_i,
    output logic        spin_valid_o,
    output spin_vec_t   spin_o,
    output logic        idle_o
);

    sync_depth_t depth_q;
    sync_mode_e  mode_q;
    logic        depth_legal;
    logic        cfg_accept;
    logic        finish_q;
    logic        finish_edge;
    logic        settle_q;
    logic        settle_done;
    logic        shift_en;
    logic        spin_handshake;
    spin_vec_t   sync_q [1:`ISING_SYNC_MAX_DEPTH];

    assign idle_o         = ~(spin_valid_o | settle_q);
    assign spin_handshake = spin_valid_o & spin_ready_i;

    // Config only taken between runs, so spin_o never jumps stage
    assign depth_legal = (cfg_sync_depth_i != '0) &&
                         (cfg_sync_depth_i <= sync_depth_t'(`ISING_SYNC_MAX_DEPTH));
    assign cfg_accept  = en_i & cfg_we_i & depth_legal & idle_o;

    // Edges during a pending result are dropped
    assign finish_edge = en_i & cmpt_finish_i & ~finish_q & idle_o;

    // One-shot shifts only while settling, continuous until valid
    assign shift_en = en_i & ((settle_q & ~settle_done) |
                              ((mode_q == SYNC_CONTINUOUS) & ~spin_valid_o));

    assign spin_o = sync_q[depth_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            depth_q <= sync_depth_t'(`ISING_SYNC_MAX_DEPTH);
            mode_q  <= SYNC_ONE_SHOT;
        end else if (cfg_accept) begin
            depth_q <= cfg_sync_depth_i;
            mode_q  <= cfg_sync_mode_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            finish_q <= 1'b0;
        end else begin
            finish_q <= cmpt_finish_i;
        end
    end

    // Synchronizer chain, stage 1 samples the macro directly
    always_ff @(posedge clk_i) begin
        if (shift_en) begin
            sync_q[1] <= spin_i;
            for (int k = 2; k <= `ISING_SYNC_MAX_DEPTH; k++) begin
                sync_q[k] <= sync_q[k-1];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            settle_q <= 1'b0;
        end else if (!en_i) begin
            settle_q <= 1'b0;
        end else if (finish_edge) begin
            settle_q <= 1'b1;
        end else if (settle_done) begin
            settle_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_valid_o <= 1'b0;
        end else if (!en_i || spin_handshake) begin
            spin_valid_o <= 1'b0;
        end else if (settle_done) begin
            spin_valid_o <= 1'b1;
        end
    end

    // Settle timer, reloaded with the current depth each run
    step_counter #(
        .COUNTER_WIDTH ($bits(sync_depth_t))
    ) u_step_counter (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .en_i         (en_i),
        .load_i       (finish_edge),
        .d_i          (depth_q),
        .recount_en_i (finish_edge),
        .step_en_i    (en_i),
        .overflow_o   (settle_done)
    );

    // Consumer stall must see a frozen vector
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_i && spin_valid_o && !spin_ready_i) |=> $stable(spin_o));

    // Depth zero would select no synchronizer stage
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_i && cfg_we_i) |-> (cfg_sync_depth_i != '0));

endmodule

`default_nettype wire

// File: rtl/cmpt_timer.sv
////////////////////////////////////////////////////////////
// Anneal run timer
// Counts cycles from anneal start to the finish edge and
// holds the run time until it is taken
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cmpt_timer
    import ising_readout_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic        anneal_start_i,
    input  logic        cmpt_finish_i,
    input  logic        time_ready_i,
    output logic        time_valid_o,
    output run_cycles_t time_cycles_o
);

    logic        finish_q;
    logic        finish_edge;
    logic        busy_q;
    logic        time_handshake;
    run_cycles_t count_q;

    assign finish_edge    = cmpt_finish_i & ~finish_q;
    assign time_handshake = time_valid_o & time_ready_i;
    assign time_cycles_o  = count_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            finish_q <= 1'b0;
        end else begin
            finish_q <= cmpt_finish_i;
        end
    end

    // Count is zero at the end of the start cycle
    // so the frozen value is finish cycle minus start cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q       <= 1'b0;
            time_valid_o <= 1'b0;
            count_q      <= '0;
        end else if (!en_i) begin
            busy_q       <= 1'b0;
            time_valid_o <= 1'b0;
        end else begin
            if (time_handshake) begin
                time_valid_o <= 1'b0;
            end
            if (anneal_start_i) begin
                busy_q  <= 1'b1;
                count_q <= '0;
            end else if (busy_q) begin
                // Saturate instead of wrapping on very long runs
                if (count_q != '1) begin
                    count_q <= count_q + 1'b1;
                end
                if (finish_edge) begin
                    busy_q       <= 1'b0;
                    time_valid_o <= 1'b1;
                end
            end
        end
    end

    // A new run would overwrite the held run time
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_i && anneal_start_i) |-> !time_valid_o);

endmodule

`default_nettype wire

// File: rtl/result_packer.sv
////////////////////////////////////////////////////////////
// Result packer
// Joins spins and run time into one indexed result record
// with output back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module result_packer
    import ising_readout_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic        spin_valid_i,
    input  spin_vec_t   spin_i,
    input  logic        time_valid_i,
    input  run_cycles_t time_cycles_i,
    input  logic        result_ready_i,
    output logic        spin_ready_o,
    output logic        time_ready_o,
    output logic        result_valid_o,
    output spin_vec_t   result_spin_o,
    output run_cycles_t result_cycles_o,
    output run_index_t  result_index_o
);

    logic       take;
    logic       result_handshake;
    run_index_t index_q;

    // Both sources are consumed together into an empty output slot
    assign take             = en_i & spin_valid_i & time_valid_i & ~result_valid_o;
    assign spin_ready_o     = take;
    assign time_ready_o     = take;
    assign result_handshake = result_valid_o & result_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
        end else if (!en_i) begin
            result_valid_o <= 1'b0;
        end else if (take) begin
            result_valid_o <= 1'b1;
        end else if (result_handshake) begin
            result_valid_o <= 1'b0;
        end
    end

    // First record carries sequence number zero
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            index_q <= '0;
        end else if (take) begin
            index_q <= index_q + 1'b1;
        end
    end

    // Record payload held while the consumer stalls
    always_ff @(posedge clk_i) begin
        if (take) begin
            result_spin_o   <= spin_i;
            result_cycles_o <= time_cycles_i;
            result_index_o  <= index_q;
        end
    end

    // A stalled record stays valid and unchanged
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (en_i && result_valid_o && !result_ready_i) |=>
            (result_valid_o &&
             $stable({result_spin_o, result_cycles_o, result_index_o})));

endmodule

`default_nettype wire

// File: rtl/ising_readout_top.sv
////////////////////////////////////////////////////////////
// Ising solver readout top level
// Spin synchronizer and run timer in parallel, joined by
// the result packer into one record per anneal run
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ising_readout_top
    import ising_readout_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic        cfg_we_i,
    input  sync_depth_t cfg_sync_depth_i,
    input  sync_mode_e  cfg_sync_mode_i,
    input  logic        anneal_start_i,
    input  spin_vec_t   spin_i,
    input  logic        cmpt_finish_i,
    input  logic        result_ready_i,
    output logic        result_valid_o,
    output spin_vec_t   result_spin_o,
    output run_cycles_t result_cycles_o,
    output run_index_t  result_index_o,
    output logic        idle_o
);

    logic        spin_valid;
    logic        spin_ready;
    spin_vec_t   spin_sync;
    logic        time_valid;
    logic        time_ready;
    run_cycles_t time_cycles;

    // Spin capture from the analog macro
    analog_tx u_analog_tx (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .en_i             (en_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_sync_depth_i (cfg_sync_depth_i),
        .cfg_sync_mode_i  (cfg_sync_mode_i),
        .spin_i           (spin_i),
        .cmpt_finish_i    (cmpt_finish_i),
        .spin_ready_i     (spin_ready),
        .spin_valid_o     (spin_valid),
        .spin_o           (spin_sync),
        .idle_o           (idle_o)
    );

    // Run length measurement
    cmpt_timer u_cmpt_timer (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (en_i),
        .anneal_start_i (anneal_start_i),
        .cmpt_finish_i  (cmpt_finish_i),
        .time_ready_i   (time_ready),
        .time_valid_o   (time_valid),
        .time_cycles_o  (time_cycles)
    );

    result_packer u_result_packer (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .en_i            (en_i),
        .spin_valid_i    (spin_valid),
        .spin_i          (spin_sync),
        .time_valid_i    (time_valid),
        .time_cycles_i   (time_cycles),
        .result_ready_i  (result_ready_i),
        .spin_ready_o    (spin_ready),
        .time_ready_o    (time_ready),
        .result_valid_o  (result_valid_o),
        .result_spin_o   (result_spin_o),
        .result_cycles_o (result_cycles_o),
        .result_index_o  (result_index_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_ising_readout.sv
////////////////////////////////////////////////////////////
// Ising readout testbench
// Replays the run vectors against the readout top level and
// checks each result record, stalls and the run index
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "ising_readout_params.svh"

module tb_ising_readout
    import ising_readout_pkg::*;
;

    logic        clk_i;
    logic        arst_n_i;
    logic        en_i;
    logic        cfg_we_i;
    sync_depth_t cfg_sync_depth_i;
    sync_mode_e  cfg_sync_mode_i;
    logic        anneal_start_i;
    spin_vec_t   spin_i;
    logic        cmpt_finish_i;
    logic        result_ready_i;
    logic        result_valid_o;
    spin_vec_t   result_spin_o;
    run_cycles_t result_cycles_o;
    run_index_t  result_index_o;
    logic        idle_o;

    ising_readout_top uut (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .en_i             (en_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_sync_depth_i (cfg_sync_depth_i),
        .cfg_sync_mode_i  (cfg_sync_mode_i),
        .anneal_start_i   (anneal_start_i),
        .spin_i           (spin_i),
        .cmpt_finish_i    (cmpt_finish_i),
        .result_ready_i   (result_ready_i),
        .result_valid_o   (result_valid_o),
        .result_spin_o    (result_spin_o),
        .result_cycles_o  (result_cycles_o),
        .result_index_o   (result_index_o),
        .idle_o           (idle_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic abort_run(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic write_config(input int mode, input int depth);
        cfg_we_i         = 1'b1;
        cfg_sync_mode_i  = sync_mode_e'(mode[0]);
        cfg_sync_depth_i = sync_depth_t'(depth);
        next_cycle();
        cfg_we_i = 1'b0;
    endtask

    // Start is sampled at S and finish first sampled high at S plus cycles
    task automatic drive_run(input spin_vec_t spins, input int cycles);
        spin_i         = spins;
        anneal_start_i = 1'b1;
        cmpt_finish_i  = 1'b0;
        next_cycle();
        anneal_start_i = 1'b0;
        for (int i = 1; i < cycles; i++) begin
            check_value("result_valid_o during run", result_valid_o, 1'b0);
            next_cycle();
        end
        cmpt_finish_i = 1'b1;
    endtask

    task automatic wait_result(input int limit);
        int waited;
        waited = 0;
        while (result_valid_o !== 1'b1) begin
            if (waited >= limit) begin
                abort_run("timeout waiting for a result record");
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic check_record(input spin_vec_t spins, input int cycles,
                                input run_index_t index);
        check_value("result_valid_o", result_valid_o, 1'b1);
        check_value("result_spin_o", result_spin_o, spins);
        check_value("result_cycles_o", result_cycles_o, cycles);
        check_value("result_index_o", result_index_o, index);
    endtask

    initial begin
        int         seed_init;
        int         fd;
        int         code;
        int         runs;
        int         mode_val;
        int         depth_val;
        int         cycles_val;
        int         stall_val;
        int         exp_cycles;
        spin_vec_t  spin_val;
        spin_vec_t  exp_spin;
        run_index_t exp_index;
        string      line;

        arst_n_i         = 1'b0;
        en_i             = 1'b0;
        cfg_we_i         = 1'b0;
        cfg_sync_depth_i = sync_depth_t'(`ISING_SYNC_MAX_DEPTH);
        cfg_sync_mode_i  = SYNC_ONE_SHOT;
        anneal_start_i   = 1'b0;
        spin_i           = '0;
        cmpt_finish_i    = 1'b0;
        result_ready_i   = 1'b0;
        seed_init        = $urandom(24498);
        runs             = 0;
        exp_index        = '0;

        repeat (16) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        en_i     = 1'b1;
        check_value("idle_o after reset", idle_o, 1'b1);
        check_value("result_valid_o after reset", result_valid_o, 1'b0);

        fd = $fopen("sim/ising_readout_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the vector file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%d %d %h %d %d %h %d", mode_val, depth_val,
                               spin_val, cycles_val, stall_val, exp_spin, exp_cycles);
                if (code != 7) begin
                    abort_run("malformed line in the vector file");
                end
                // Random idle gap between runs
                repeat ($urandom % 4) next_cycle();
                write_config(mode_val, depth_val);
                drive_run(spin_val, cycles_val);
                wait_result(32);
                check_record(exp_spin, exp_cycles, exp_index);
                // Record must not move during a consumer stall
                for (int i = 0; i < stall_val; i++) begin
                    next_cycle();
                    check_record(exp_spin, exp_cycles, exp_index);
                end
                result_ready_i = 1'b1;
                next_cycle();
                result_ready_i = 1'b0;
                check_value("result_valid_o after accept", result_valid_o, 1'b0);
                check_value("idle_o after accept", idle_o, 1'b1);
                exp_index = exp_index + 1'b1;
                runs++;
            end
        end
        $fclose(fd);
        check_value("runs replayed nonzero", (runs != 0), 1'b1);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ising_readout_vectors.txt
# mode(0 one-shot, 1 continuous) depth spins(hex) start-to-finish cycles stall cycles
# expected spins(hex) expected run cycles
0 1 a5c3 5 0 a5c3 5
0 2 3c96 12 2 3c96 12
0 3 f00f 1 0 f00f 1
0 4 8001 7 3 8001 7
0 1 0000 2 1 0000 2
0 2 ffff 20 0 ffff 20
0 3 1234 9 5 1234 9
0 4 fedc 33 0 fedc 33
0 1 0001 1 2 0001 1
0 2 8000 3 0 8000 3
0 3 5555 17 1 5555 17
0 4 aaaa 4 6 aaaa 4
1 1 5a5a 8 0 5a5a 8
1 2 c3a5 15 4 c3a5 15
1 3 0ff0 3 0 0ff0 3
1 4 7e81 40 2 7e81 40
1 1 ffff 1 0 ffff 1
1 2 0000 6 3 0000 6
1 3 9abc 11 0 9abc 11
1 4 4321 2 1 4321 2
0 4 1111 10 0 1111 10
0 3 2222 25 7 2222 25
0 2 4444 64 0 4444 64
0 1 8888 100 2 8888 100
1 4 f0f0 5 0 f0f0 5
1 3 0f0f 13 2 0f0f 13
1 2 3333 7 0 3333 7
1 1 cccc 19 1 cccc 19
0 1 6b2d 255 0 6b2d 255
0 2 d2b6 256 3 d2b6 256
0 4 dead 65535 1 dead 65535
0 2 beef 65536 0 beef 65535
1 3 cafe 70000 2 cafe 65535
0 3 7777 3 0 7777 3
1 1 1357 4 1 1357 4
0 4 2468 6 0 2468 6
0 1 ace1 2 0 ace1 2
1 2 bd02 9 3 bd02 9

// File: ising_readout_top.f
+incdir+common
common/ising_readout_pkg.sv
analog_tx/step_counter.sv
analog_tx/analog_tx.sv
rtl/cmpt_timer.sv
rtl/result_packer.sv
rtl/ising_readout_top.sv
sim/tb_ising_readout.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the readout testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ising_readout \
    --Mdir obj_dir \
    -f ising_readout_top.f \
    && ./obj_dir/Vtb_ising_readout | tee /dev/stderr | grep -q "^Test passed$" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
